/* hdl/dmr_pkg.sv */
package dmr_pkg;

    // Data word carried through the unit
    localparam int data_w = 16;

    // Operation field, one value per operation group
    localparam int op_w = 2;
    localparam int num_opgroups = 3;

    // Transaction ids
    // The id count also bounds the number of transactions in flight
    localparam int id_w = 3;
    localparam int num_ids = 8;

    // Pipeline depth of each operation group, indexed by group
    localparam int opgroup_depth [num_opgroups] = '{2, 4, 6};

    typedef logic [data_w-1:0] data_t;
    typedef logic [op_w-1:0]   op_t;
    typedef logic [id_w-1:0]   id_t;

endpackage

/* hdl/retry_start.sv */
`timescale 1ns/1ps

module retry_start (
    input  logic           clk_i,
    input  logic           rst_i,
    // Upstream
    input  logic           valid_i,
    input  dmr_pkg::data_t data_i,
    input  dmr_pkg::op_t   operation_i,
    output logic           ready_o,
    // Downstream towards the redundant issue stage
    output logic           valid_o,
    output dmr_pkg::data_t data_o,
    output dmr_pkg::op_t   operation_o,
    output dmr_pkg::id_t   id_o,
    input  logic           ready_i,
    // Failed ids coming back from the compare stage
    input  logic           retry_valid_i,
    input  dmr_pkg::id_t   retry_id_i,
    output logic           retry_ready_o,
    // Completion strobe
    input  logic           done_i,
    input  dmr_pkg::id_t   done_id_i
);

    // Stored transactions, indexed by id
    dmr_pkg::op_t   op_mem   [dmr_pkg::num_ids];
    dmr_pkg::data_t data_mem [dmr_pkg::num_ids];

    logic [dmr_pkg::num_ids-1:0] busy_q;
    logic [dmr_pkg::num_ids-1:0] retry_pend_q;
    logic                        run_q;
    logic                        out_free;
    logic                        new_take;
    logic                        retry_take;
    dmr_pkg::id_t                free_id;
    dmr_pkg::id_t                retry_sel;

    // Lowest free id and lowest pending retry
    always_comb begin
        free_id   = '0;
        retry_sel = '0;
        for (int i = dmr_pkg::num_ids - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                free_id = dmr_pkg::id_t'(i);
            end
            if (retry_pend_q[i]) begin
                retry_sel = dmr_pkg::id_t'(i);
            end
        end
    end

    assign out_free   = !valid_o || ready_i;
    assign retry_take = out_free && (|retry_pend_q);
    assign new_take   = valid_i && ready_o;

    // New work waits for every queued retry and for a free id
    assign ready_o = run_q && out_free && !retry_valid_i && !(|retry_pend_q) && !(&busy_q);

    // A failed id is queued once until it is issued again
    assign retry_ready_o = !retry_pend_q[retry_id_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            run_q        <= 1'b0;
            valid_o      <= 1'b0;
            busy_q       <= '0;
            retry_pend_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (out_free) begin
                valid_o <= retry_take || new_take;
            end
            if (done_i) begin
                busy_q[done_id_i] <= 1'b0;
            end
            if (new_take) begin
                busy_q[free_id] <= 1'b1;
            end
            if (retry_take) begin
                retry_pend_q[retry_sel] <= 1'b0;
            end
            if (retry_valid_i && retry_ready_o) begin
                retry_pend_q[retry_id_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_take) begin
            op_mem[free_id]   <= operation_i;
            data_mem[free_id] <= data_i;
        end
    end

    // Output register, retries ahead of new work
    always_ff @(posedge clk_i) begin
        if (retry_take) begin
            data_o      <= data_mem[retry_sel];
            operation_o <= op_mem[retry_sel];
            id_o        <= retry_sel;
        end else if (new_take) begin
            data_o      <= data_i;
            operation_o <= operation_i;
            id_o        <= free_id;
        end
    end

endmodule

/* hdl/time_dmr_start.sv */
`timescale 1ns/1ps

module time_dmr_start (
    input  logic           clk_i,
    input  logic           rst_i,
    // Upstream
    input  logic           valid_i,
    input  dmr_pkg::data_t data_i,
    input  dmr_pkg::op_t   operation_i,
    input  dmr_pkg::id_t   id_i,
    output logic           ready_o,
    // Downstream, two copies per transaction
    output logic           valid_o,
    output dmr_pkg::data_t data_o,
    output dmr_pkg::op_t   operation_o,
    output dmr_pkg::id_t   id_o,
    input  logic           ready_i,
    // Fault injection
    input  logic           fault_i,
    input  dmr_pkg::data_t fault_mask_i
);

    dmr_pkg::data_t data_q;
    logic           second_q;
    logic           fault_q;
    logic           xfer_out;

    assign xfer_out = valid_o && ready_i;

    // Take a new transaction only once the second copy leaves
    assign ready_o = !valid_o || (second_q && ready_i);

    // Corrupt the copy on the port while a fault is armed
    assign data_o = fault_q ? (data_q ^ fault_mask_i) : data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o  <= 1'b0;
            second_q <= 1'b0;
            fault_q  <= 1'b0;
        end else begin
            if (valid_i && ready_o) begin
                valid_o  <= 1'b1;
                second_q <= 1'b0;
            end else if (xfer_out) begin
                valid_o  <= !second_q;
                second_q <= !second_q;
            end
            // Sticky until the next copy transfers
            if (fault_i) begin
                fault_q <= 1'b1;
            end else if (xfer_out) begin
                fault_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q      <= data_i;
            operation_o <= operation_i;
            id_o        <= id_i;
        end
    end

endmodule

/* hdl/opgroup_pipe.sv */
`timescale 1ns/1ps

module opgroup_pipe #(
    parameter int depth = 2
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           valid_i,
    input  dmr_pkg::data_t data_i,
    input  dmr_pkg::id_t   id_i,
    output logic           ready_o,
    output logic           valid_o,
    output dmr_pkg::data_t data_o,
    output dmr_pkg::id_t   id_o,
    input  logic           ready_i
);

    // Index i holds the signal after i register stages
    logic           [depth:0] pipe_valid;
    logic           [depth:0] pipe_ready;
    dmr_pkg::data_t [depth:0] pipe_data;
    dmr_pkg::id_t   [depth:0] pipe_id;

    assign pipe_valid[0] = valid_i;
    assign pipe_data[0]  = data_i;
    assign pipe_id[0]    = id_i;
    assign ready_o       = pipe_ready[0];

    for (genvar i = 0; i < depth; i++) begin : gen_stage
        // Advance when the next stage moves on or only holds a bubble
        assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid[i+1];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                pipe_valid[i+1] <= 1'b0;
            end else if (pipe_ready[i]) begin
                pipe_valid[i+1] <= pipe_valid[i];
            end
        end

        // Payload only loads with a valid item
        always_ff @(posedge clk_i) begin
            if (pipe_ready[i] && pipe_valid[i]) begin
                pipe_data[i+1] <= pipe_data[i];
                pipe_id[i+1]   <= pipe_id[i];
            end
        end
    end

    assign pipe_ready[depth] = ready_i;
    assign valid_o           = pipe_valid[depth];
    assign data_o            = pipe_data[depth];
    assign id_o              = pipe_id[depth];

endmodule

/* hdl/opgroup_arbiter.sv */
`timescale 1ns/1ps

module opgroup_arbiter (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         lock_i,
    // One request per operation group
    input  logic           [dmr_pkg::num_opgroups-1:0]   req_i,
    input  dmr_pkg::data_t [dmr_pkg::num_opgroups-1:0]   data_i,
    input  dmr_pkg::id_t   [dmr_pkg::num_opgroups-1:0]   id_i,
    output logic           [dmr_pkg::num_opgroups-1:0]   gnt_o,
    // Arbitrated output
    output logic                                         valid_o,
    output dmr_pkg::data_t                               data_o,
    output dmr_pkg::id_t                                 id_o,
    output dmr_pkg::op_t                                 operation_o,
    input  logic                                         ready_i
);

    dmr_pkg::op_t ptr_q;
    dmr_pkg::op_t last_q;
    dmr_pkg::op_t sel;
    logic         xfer;

    // First requester at or after the pointer
    always_comb begin
        int   idx;
        logic found;
        found = 1'b0;
        sel   = ptr_q;
        for (int k = 0; k < dmr_pkg::num_opgroups; k++) begin
            idx = (int'(ptr_q) + k) % dmr_pkg::num_opgroups;
            if (!found && req_i[idx]) begin
                sel   = dmr_pkg::op_t'(idx);
                found = 1'b1;
            end
        end
        // Hold the group whose first copy is waiting for its twin
        if (lock_i) begin
            sel = last_q;
        end
    end

    always_comb begin
        gnt_o      = '0;
        gnt_o[sel] = ready_i;
    end

    assign valid_o     = req_i[sel];
    assign data_o      = data_i[sel];
    assign id_o        = id_i[sel];
    assign operation_o = sel;
    assign xfer        = valid_o && ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q  <= '0;
            last_q <= '0;
        end else if (xfer) begin
            last_q <= sel;
            // Move past the winner
            if (sel == dmr_pkg::op_t'(dmr_pkg::num_opgroups - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= sel + 1'b1;
            end
        end
    end

endmodule

/* hdl/time_dmr_end.sv */
`timescale 1ns/1ps

module time_dmr_end (
    input  logic           clk_i,
    input  logic           rst_i,
    // Copies from the arbiter
    input  logic           valid_i,
    input  dmr_pkg::data_t data_i,
    input  dmr_pkg::op_t   operation_i,
    input  dmr_pkg::id_t   id_i,
    output logic           ready_o,
    output logic           lock_o,
    // Result
    output logic           valid_o,
    output dmr_pkg::data_t data_o,
    output dmr_pkg::op_t   operation_o,
    input  logic           ready_i,
    output logic           mismatch_o,
    // Failed id back to the retry stage
    output logic           retry_valid_o,
    output dmr_pkg::id_t   retry_id_o,
    input  logic           retry_ready_i,
    // Completion strobe
    output logic           done_o,
    output dmr_pkg::id_t   done_id_o
);

    // First copy of the current pair
    logic           held_q;
    dmr_pkg::data_t held_data;
    dmr_pkg::op_t   held_op;
    dmr_pkg::id_t   held_id;

    // Id of the result on the output port
    dmr_pkg::id_t   res_id_q;

    logic xfer_in;
    logic pair_done;
    logic match;
    logic out_free;
    logic res_xfer;

    assign res_xfer  = valid_o && ready_i;
    assign out_free  = (!valid_o || ready_i) && (!retry_valid_o || retry_ready_i);

    // A first copy is always taken; the second needs room for its outcome
    assign ready_o   = !held_q || out_free;
    assign xfer_in   = valid_i && ready_o;
    assign pair_done = xfer_in && held_q;
    assign match     = (data_i == held_data) && (operation_i == held_op) && (id_i == held_id);

    // Arbiter stays on this group until the twin arrives
    assign lock_o = held_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            held_q        <= 1'b0;
            valid_o       <= 1'b0;
            retry_valid_o <= 1'b0;
            mismatch_o    <= 1'b0;
            done_o        <= 1'b0;
        end else begin
            if (xfer_in) begin
                held_q <= !held_q;
            end
            if (pair_done && match) begin
                valid_o <= 1'b1;
            end else if (ready_i) begin
                valid_o <= 1'b0;
            end
            if (pair_done && !match) begin
                retry_valid_o <= 1'b1;
            end else if (retry_ready_i) begin
                retry_valid_o <= 1'b0;
            end
            mismatch_o <= pair_done && !match;
            done_o     <= res_xfer;
        end
    end

    always_ff @(posedge clk_i) begin
        if (xfer_in && !held_q) begin
            held_data <= data_i;
            held_op   <= operation_i;
            held_id   <= id_i;
        end
        if (pair_done && match) begin
            data_o      <= held_data;
            operation_o <= held_op;
            res_id_q    <= held_id;
        end
        if (pair_done && !match) begin
            retry_id_o <= held_id;
        end
        if (res_xfer) begin
            done_id_o <= res_id_q;
        end
    end

endmodule

/* hdl/dmr_retry_unit.sv */
`timescale 1ns/1ps

module dmr_retry_unit (
    input  logic           clk_i,
    input  logic           rst_i,
    // Upstream
    input  logic           valid_i,
    input  dmr_pkg::data_t data_i,
    input  dmr_pkg::op_t   operation_i,
    output logic           ready_o,
    // Downstream
    output logic           valid_o,
    output dmr_pkg::data_t data_o,
    output dmr_pkg::op_t   operation_o,
    input  logic           ready_i,
    output logic           mismatch_o,
    // Fault injection
    input  logic           fault_i,
    input  dmr_pkg::data_t fault_mask_i
);

    // Retry stage to issue stage
    logic           rs_valid, rs_ready;
    dmr_pkg::data_t rs_data;
    dmr_pkg::op_t   rs_op;
    dmr_pkg::id_t   rs_id;

    // Issued copies
    logic           cp_valid, cp_ready;
    dmr_pkg::data_t cp_data;
    dmr_pkg::op_t   cp_op;
    dmr_pkg::id_t   cp_id;

    // Operation groups
    logic           [dmr_pkg::num_opgroups-1:0] grp_sel;
    logic           [dmr_pkg::num_opgroups-1:0] grp_in_ready;
    logic           [dmr_pkg::num_opgroups-1:0] grp_valid;
    logic           [dmr_pkg::num_opgroups-1:0] grp_gnt;
    dmr_pkg::data_t [dmr_pkg::num_opgroups-1:0] grp_data;
    dmr_pkg::id_t   [dmr_pkg::num_opgroups-1:0] grp_id;

    // Arbiter output
    logic           arb_valid, arb_ready;
    dmr_pkg::data_t arb_data;
    dmr_pkg::op_t   arb_op;
    dmr_pkg::id_t   arb_id;

    // Feedback from the compare stage
    logic           lock;
    logic           retry_valid, retry_ready;
    dmr_pkg::id_t   retry_id;
    logic           done;
    dmr_pkg::id_t   done_id;

    retry_start i_retry_start (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .data_i        (data_i),
        .operation_i   (operation_i),
        .ready_o       (ready_o),
        .valid_o       (rs_valid),
        .data_o        (rs_data),
        .operation_o   (rs_op),
        .id_o          (rs_id),
        .ready_i       (rs_ready),
        .retry_valid_i (retry_valid),
        .retry_id_i    (retry_id),
        .retry_ready_o (retry_ready),
        .done_i        (done),
        .done_id_i     (done_id)
    );

    time_dmr_start i_time_dmr_start (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (rs_valid),
        .data_i       (rs_data),
        .operation_i  (rs_op),
        .id_i         (rs_id),
        .ready_o      (rs_ready),
        .valid_o      (cp_valid),
        .data_o       (cp_data),
        .operation_o  (cp_op),
        .id_o         (cp_id),
        .ready_i      (cp_ready),
        .fault_i      (fault_i),
        .fault_mask_i (fault_mask_i)
    );

    // Ready returned from the group the copy is steered to
    assign cp_ready = |(grp_sel & grp_in_ready);

    for (genvar g = 0; g < dmr_pkg::num_opgroups; g++) begin : gen_opgroups
        assign grp_sel[g] = (cp_op == dmr_pkg::op_t'(g));

        opgroup_pipe #(
            .depth (dmr_pkg::opgroup_depth[g])
        ) i_opgroup_pipe (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .valid_i (cp_valid && grp_sel[g]),
            .data_i  (cp_data),
            .id_i    (cp_id),
            .ready_o (grp_in_ready[g]),
            .valid_o (grp_valid[g]),
            .data_o  (grp_data[g]),
            .id_o    (grp_id[g]),
            .ready_i (grp_gnt[g])
        );
    end

    opgroup_arbiter i_opgroup_arbiter (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .lock_i      (lock),
        .req_i       (grp_valid),
        .data_i      (grp_data),
        .id_i        (grp_id),
        .gnt_o       (grp_gnt),
        .valid_o     (arb_valid),
        .data_o      (arb_data),
        .id_o        (arb_id),
        .operation_o (arb_op),
        .ready_i     (arb_ready)
    );

    time_dmr_end i_time_dmr_end (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .valid_i       (arb_valid),
        .data_i        (arb_data),
        .operation_i   (arb_op),
        .id_i          (arb_id),
        .ready_o       (arb_ready),
        .lock_o        (lock),
        .valid_o       (valid_o),
        .data_o        (data_o),
        .operation_o   (operation_o),
        .ready_i       (ready_i),
        .mismatch_o    (mismatch_o),
        .retry_valid_o (retry_valid),
        .retry_id_o    (retry_id),
        .retry_ready_i (retry_ready),
        .done_o        (done),
        .done_id_o     (done_id)
    );

endmodule

/* tb/tb_dmr_retry_unit.sv */
`timescale 1ns/1ps

module tb_dmr_retry_unit;

    localparam logic [31:0] seed = 32'hc9ad255b;
    localparam int num_tests = 5;
    localparam int test_budget_ns = 2000;
    localparam int drain_limit = 400;
    // Cycles of held valid without ready that count as a stall
    localparam int stall_cycles = 12;
    // Enough transactions to pass the id count plus one
    localparam int fill_txns = 12;

    logic           clk_i;
    logic           rst_i;
    logic           valid_i;
    dmr_pkg::data_t data_i;
    dmr_pkg::op_t   operation_i;
    logic           ready_o;
    logic           valid_o;
    dmr_pkg::data_t data_o;
    dmr_pkg::op_t   operation_o;
    logic           ready_i;
    logic           mismatch_o;
    logic           fault_i;
    dmr_pkg::data_t fault_mask_i;

    // Expected results, one queue per operation
    dmr_pkg::data_t q_op0[$];
    dmr_pkg::data_t q_op1[$];
    dmr_pkg::data_t q_op2[$];

    int             err_cnt;
    int             result_cnt;
    int             mismatch_cnt;
    int             accepted_cnt;
    dmr_pkg::data_t last_data;
    dmr_pkg::op_t   last_op;
    logic [31:0]    lcg_state;
    logic           feed_done;

    dmr_retry_unit i_dmr_retry_unit (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .valid_i      (valid_i),
        .data_i       (data_i),
        .operation_i  (operation_i),
        .ready_o      (ready_o),
        .valid_o      (valid_o),
        .data_o       (data_o),
        .operation_o  (operation_o),
        .ready_i      (ready_i),
        .mismatch_o   (mismatch_o),
        .fault_i      (fault_i),
        .fault_mask_i (fault_mask_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pending();
        return q_op0.size() + q_op1.size() + q_op2.size();
    endfunction

    task automatic report_error(input string msg);
        err_cnt++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_data(input string name, input dmr_pkg::data_t exp,
                              input dmr_pkg::data_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("FAILED at %0t: %s expected 0x%04h, got 0x%04h", $time, name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input dmr_pkg::op_t exp, input dmr_pkg::op_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            err_cnt++;
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic push_expected(input dmr_pkg::op_t op, input dmr_pkg::data_t data);
        case (op)
            2'd0: q_op0.push_back(data);
            2'd1: q_op1.push_back(data);
            2'd2: q_op2.push_back(data);
            default: report_error("stimulus used an operation with no group");
        endcase
    endtask

    // Called at the drive point, returns at the next drive point
    task automatic send_txn(input dmr_pkg::op_t op, input dmr_pkg::data_t data);
        valid_i     = 1'b1;
        data_i      = data;
        operation_i = op;
        @(negedge clk_i);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        // Transfer happens on the coming edge
        push_expected(op, data);
        accepted_cnt++;
        @(posedge clk_i);
        #2;
        valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending() != 0 && cycles < drain_limit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (pending() != 0) begin
            report_error($sformatf("%0d results still missing at the end of a test", pending()));
        end
        @(posedge clk_i);
        #2;
    endtask

    // Transfers are decided here, half a cycle before the edge
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (mismatch_o) begin
                mismatch_cnt++;
            end
            if (valid_o && ready_i) begin
                result_cnt++;
                last_data = data_o;
                last_op   = operation_o;
                case (operation_o)
                    2'd0: begin
                        if (q_op0.size() == 0) begin
                            report_error("result for operation 0 arrived with its queue empty");
                        end else begin
                            check_data("data_o", q_op0.pop_front(), data_o);
                        end
                    end
                    2'd1: begin
                        if (q_op1.size() == 0) begin
                            report_error("result for operation 1 arrived with its queue empty");
                        end else begin
                            check_data("data_o", q_op1.pop_front(), data_o);
                        end
                    end
                    2'd2: begin
                        if (q_op2.size() == 0) begin
                            report_error("result for operation 2 arrived with its queue empty");
                        end else begin
                            check_data("data_o", q_op2.pop_front(), data_o);
                        end
                    end
                    default: report_error("result carried an operation with no group");
                endcase
            end
        end
    end

    task automatic single_per_op();
        int             res_before;
        int             mm_before;
        dmr_pkg::op_t   op;
        dmr_pkg::data_t data;
        logic [31:0]    r;
        mm_before = mismatch_cnt;
        for (int i = 0; i < dmr_pkg::num_opgroups; i++) begin
            r          = next_rand();
            op         = dmr_pkg::op_t'(i);
            data       = r[31:16];
            res_before = result_cnt;
            send_txn(op, data);
            wait_drain();
            check_count("results", res_before + 1, result_cnt);
            check_data("data_o", data, last_data);
            check_op("operation_o", op, last_op);
        end
        check_count("mismatch_o pulses", mm_before, mismatch_cnt);
    endtask

    task automatic random_stream();
        int          res_before;
        int          mm_before;
        logic [31:0] r;
        res_before = result_cnt;
        mm_before  = mismatch_cnt;
        for (int i = 0; i < 60; i++) begin
            r = next_rand();
            send_txn(dmr_pkg::op_t'(r[15:0] % dmr_pkg::num_opgroups), r[31:16]);
        end
        wait_drain();
        check_count("results", res_before + 60, result_cnt);
        check_count("mismatch_o pulses", mm_before, mismatch_cnt);
    endtask

    task automatic throttled_stream();
        dmr_pkg::op_t   ops   [40];
        dmr_pkg::data_t datas [40];
        int             res_before;
        logic [31:0]    r;
        res_before = result_cnt;
        // Draw all stimulus before the ready pattern starts
        for (int i = 0; i < 40; i++) begin
            r        = next_rand();
            ops[i]   = dmr_pkg::op_t'(r[15:0] % dmr_pkg::num_opgroups);
            datas[i] = r[31:16];
        end
        feed_done = 1'b0;
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    send_txn(ops[i], datas[i]);
                end
                feed_done = 1'b1;
            end
            begin
                while (!feed_done) begin
                    @(posedge clk_i);
                    #2;
                    r       = next_rand();
                    ready_i = |r[17:16];
                end
            end
        join
        ready_i = 1'b1;
        wait_drain();
        check_count("results", res_before + 40, result_cnt);
    endtask

    task automatic fault_and_retry();
        dmr_pkg::data_t data;
        int             mm_before;
        logic [31:0]    r;
        for (int i = 0; i < dmr_pkg::num_opgroups; i++) begin
            r         = next_rand();
            data      = r[31:16];
            mm_before = mismatch_cnt;
            fault_i      = 1'b1;
            fault_mask_i = r[15:0] | 16'h0001;
            @(posedge clk_i);
            #2;
            fault_i = 1'b0;
            send_txn(dmr_pkg::op_t'(i), data);
            wait_drain();
            fault_mask_i = '0;
            check_count("mismatch_o pulses", mm_before + 1, mismatch_cnt);
            check_data("data_o", data, last_data);
        end
    endtask

    task automatic fill_id_table();
        int          base;
        int          res_before;
        int          run;
        logic [31:0] r;
        base       = accepted_cnt;
        res_before = result_cnt;
        ready_i    = 1'b0;
        feed_done  = 1'b0;
        run        = 0;
        fork
            begin
                for (int i = 0; i < fill_txns; i++) begin
                    r = next_rand();
                    send_txn(dmr_pkg::op_t'(i % dmr_pkg::num_opgroups), r[31:16]);
                end
                feed_done = 1'b1;
            end
            begin
                while (run < stall_cycles && !feed_done) begin
                    @(negedge clk_i);
                    if (valid_i && !ready_o) begin
                        run++;
                    end else begin
                        run = 0;
                    end
                end
                if (run < stall_cycles) begin
                    report_error("ready_o never fell while results were held back");
                end else if (accepted_cnt - base > 9) begin
                    report_error("ready_o fell only after more than 9 acceptances");
                end
                @(posedge clk_i);
                #2;
                ready_i = 1'b1;
            end
        join
        wait_drain();
        check_count("results", res_before + fill_txns, result_cnt);
    endtask

    initial begin
        #(num_tests * test_budget_ns);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        lcg_state    = seed;
        err_cnt      = 0;
        result_cnt   = 0;
        mismatch_cnt = 0;
        accepted_cnt = 0;
        feed_done    = 1'b0;
        rst_i        = 1'b1;
        valid_i      = 1'b0;
        data_i       = '0;
        operation_i  = '0;
        ready_i      = 1'b0;
        fault_i      = 1'b0;
        fault_mask_i = '0;
        repeat (4) @(posedge clk_i);
        #2;
        rst_i   = 1'b0;
        ready_i = 1'b1;

        single_per_op();
        random_stream();
        throttled_stream();
        fault_and_retry();
        fill_id_table();

        $display("Errors: %0d, results: %0d, mismatch pulses: %0d",
                 err_cnt, result_cnt, mismatch_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/dmr_pkg.sv
hdl/retry_start.sv
hdl/time_dmr_start.sv
hdl/opgroup_pipe.sv
hdl/opgroup_arbiter.sv
hdl/time_dmr_end.sv
hdl/dmr_retry_unit.sv
tb/tb_dmr_retry_unit.sv

/* Bender.yml */
package:
  name: dmr_retry_unit

sources:
  - hdl/dmr_pkg.sv
  - hdl/retry_start.sv
  - hdl/time_dmr_start.sv
  - hdl/opgroup_pipe.sv
  - hdl/opgroup_arbiter.sv
  - hdl/time_dmr_end.sv
  - hdl/dmr_retry_unit.sv
  - target: test
    files:
      - tb/tb_dmr_retry_unit.sv
